// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - rtl/lsu_pkg.sv
  - rtl/store_align.sv
  - rtl/load_extract.sv
  - rtl/access_seq.sv
  - rtl/data_ram.sv
  - rtl/mem_stage.sv
  - target: test
    files:
      - bench/mem_stage_tb.sv

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/100ps

module mem_stage_tb;

    localparam int clk_period = 20;
    localparam int n_basic    = 24;   // Iterations per directed phase.
    localparam int n_mixed    = 600;
    localparam int total_reqs = 16 * n_basic + n_mixed + 20;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             req;
    logic             we;
    lsu_pkg::funct3_t funct3;
    lsu_pkg::addr_t   addr;
    lsu_pkg::word_t   wdata;
    logic             busy;
    logic             rd_valid;
    lsu_pkg::word_t   rd_data;

    logic [7:0]       model_mem [1024];   // Byte image of the RAM.
    lsu_pkg::word_t   exp_q [$];
    int               due_q [$];
    logic             st_pend = 1'b0;
    lsu_pkg::funct3_t st_f;
    lsu_pkg::addr_t   st_a;
    lsu_pkg::word_t   st_d;
    int               hi_wait = 0;        // Edges until beat 1 of a split lands.
    int               hi_idx;
    logic [7:0]       hi_byte;
    int               cyc = 0;
    int               errors = 0;
    int               checks = 0;
    int unsigned      seed = 83241;
    lsu_pkg::addr_t   a;
    int               k;

    mem_stage UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .funct3   (funct3),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #((total_reqs * 3 + 50) * clk_period);
        $display("Timeout: the run did not finish after %0d cycles.", cyc);
        $display("Something failed");
        $finish;
    end

    task automatic check_value(input string name, input lsu_pkg::word_t actual,
                               input lsu_pkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic lsu_pkg::word_t model_load(input lsu_pkg::funct3_t f,
                                                  input lsu_pkg::addr_t la);
        int          b;
        logic [15:0] half;
        b = la[9:0];
        model_load = '0;  // Misaligned words and offset 3 halfwords.
        case (f)
            lsu_pkg::funct_lb:  model_load = {{24{model_mem[b][7]}}, model_mem[b]};
            lsu_pkg::funct_lbu: model_load = {24'd0, model_mem[b]};
            lsu_pkg::funct_lh, lsu_pkg::funct_lhu: begin
                if (la[1:0] != 2'd3) begin
                    half = {model_mem[b + 1], model_mem[b]};
                    if (f == lsu_pkg::funct_lh) model_load = {{16{half[15]}}, half};
                    else model_load = {16'd0, half};
                end
            end
            lsu_pkg::funct_lw: begin
                if (la[1:0] == 2'd0)
                    model_load = {model_mem[b + 3], model_mem[b + 2],
                                  model_mem[b + 1], model_mem[b]};
            end
            default: model_load = '0;
        endcase
    endfunction

    // Beat 0 of a store. The high byte of a split goes in separately.
    task automatic model_store(input lsu_pkg::funct3_t f, input lsu_pkg::addr_t sa,
                               input lsu_pkg::word_t d);
        int b;
        b = sa[9:0];
        if (f == lsu_pkg::funct_sb) model_mem[b] = d[7:0];
        if (f == lsu_pkg::funct_sh) begin
            model_mem[b] = d[7:0];
            if (sa[1:0] != 2'd3) model_mem[b + 1] = d[15:8];
        end
        if (f == lsu_pkg::funct_sw && sa[1:0] == 2'd0) begin
            for (int i = 0; i < 4; i++) model_mem[b + i] = d[8*i +: 8];
        end
    endtask

    task automatic run_cycle(input logic r, input logic w, input lsu_pkg::funct3_t f,
                             input lsu_pkg::addr_t ca, input lsu_pkg::word_t d);
        logic split_st;
        split_st = r && w && f == lsu_pkg::funct_sh && ca[1:0] == 2'd3;
        req    = r;
        we     = w;
        funct3 = f;
        addr   = ca;
        wdata  = d;
        @(posedge clk);
        cyc++;
        if (r && !w) begin
            exp_q.push_back(model_load(f, ca));  // Read sees memory before this edge.
            due_q.push_back(cyc + 1);
        end
        if (st_pend) model_store(st_f, st_a, st_d);
        if (hi_wait == 1) model_mem[hi_idx] = hi_byte;
        if (hi_wait > 0) hi_wait--;
        st_pend = r && w;
        st_f    = f;
        st_a    = ca;
        st_d    = d;
        if (split_st) begin
            hi_wait = 2;
            hi_idx  = ((ca[9:2] + 1) % lsu_pkg::ram_words) * 4;
            hi_byte = d[15:8];
        end
        #1;
        check_value("busy", busy, split_st);
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check_value("rd_valid", rd_valid, 1);
            check_value("rd_data", rd_data, exp_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            check_value("rd_valid", rd_valid, 0);
        end
        #1;
    endtask

    task automatic idle();
        run_cycle(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic store(input lsu_pkg::funct3_t f, input lsu_pkg::addr_t sa,
                         input lsu_pkg::word_t d);
        run_cycle(1'b1, 1'b1, f, sa, d);
        if (f == lsu_pkg::funct_sh && sa[1:0] == 2'd3) idle();  // No request while busy.
    endtask

    task automatic load(input lsu_pkg::funct3_t f, input lsu_pkg::addr_t la);
        run_cycle(1'b1, 1'b0, f, la, $urandom);
    endtask

    function automatic lsu_pkg::addr_t word_addr();
        return $urandom & 32'hffff_fffc;
    endfunction

    initial begin
        void'($urandom(seed));
        rst_n  = 1'b0;
        req    = 1'b0;
        we     = 1'b0;
        funct3 = '0;
        addr   = '0;
        wdata  = '0;
        for (int i = 0; i < 1024; i++) model_mem[i] = 8'h00;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        check_value("busy", busy, 0);
        check_value("rd_valid", rd_valid, 0);
        load(lsu_pkg::funct_lw, 32'h0);
        load(lsu_pkg::funct_lw, 32'h3fc);
        load(lsu_pkg::funct_lb, 32'h1a3);

        repeat (n_basic) begin
            a = word_addr();
            store(lsu_pkg::funct_sw, a, $urandom);
            store(lsu_pkg::funct_sb, a + $urandom_range(3, 0), $urandom);
            load(lsu_pkg::funct_lw, a);
            load(lsu_pkg::funct_lb, a + $urandom_range(3, 0));
            load(lsu_pkg::funct_lbu, a + $urandom_range(3, 0));
        end

        repeat (n_basic) begin
            a = word_addr() + $urandom_range(2, 0);
            store(lsu_pkg::funct_sh, a, $urandom);
            load(lsu_pkg::funct_lh, a);
            load(lsu_pkg::funct_lhu, a);
        end

        // Split halfwords, the last one wrapping to word 0.
        for (k = 0; k <= n_basic / 2; k++) begin
            a = (k == n_basic / 2) ? 32'h3ff : (word_addr() | 32'h3);
            store(lsu_pkg::funct_sh, a, $urandom);
            load(lsu_pkg::funct_lbu, a);
            load(lsu_pkg::funct_lbu, ((a[9:2] + 1) % lsu_pkg::ram_words) * 4);
        end

        repeat (n_basic) begin
            a = word_addr();
            store(lsu_pkg::funct_sw, a, $urandom);
            load(lsu_pkg::funct_lw, a);  // Old data.
            load(lsu_pkg::funct_lw, a);
            load(lsu_pkg::funct_lhu, a + $urandom_range(2, 0));
        end

        repeat (n_basic / 2) begin
            a = word_addr();
            store(lsu_pkg::funct_sw, a + $urandom_range(3, 1), $urandom);
            load(lsu_pkg::funct_lw, a + $urandom_range(3, 1));
            load(lsu_pkg::funct_lw, a);
            load(lsu_pkg::funct_lh, a | 32'h3);
        end

        // Mixed traffic on a few hot words.
        repeat (n_mixed) begin
            a = $urandom & 32'hffff_fc1f;
            k = $urandom_range(4, 0);
            if ($urandom_range(3, 0) == 0) idle();
            else if ($urandom_range(1, 0) == 1) store(lsu_pkg::funct3_t'(k % 3), a, $urandom);
            else load(lsu_pkg::funct3_t'(k > 2 ? k + 1 : k), a);
        end

        repeat (3) idle();
        if (due_q.size() != 0) begin
            errors++;
            $display("%0d load results never arrived.", due_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== rtl/access_seq.sv ====
`timescale 1ns/100ps

module access_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  logic                we,
    input  lsu_pkg::addr_t      addr,
    output logic                st_go,
    output logic                ld_go,
    output logic [1:0]          byte_off,
    input  logic                split,
    input  lsu_pkg::byte_en_t   be0,
    input  lsu_pkg::byte_en_t   be1,
    input  lsu_pkg::word_t      data0,
    input  lsu_pkg::word_t      data1,
    output lsu_pkg::word_addr_t rd_addr,
    output lsu_pkg::word_addr_t wr_addr,
    output lsu_pkg::byte_en_t   wr_be,
    output lsu_pkg::word_t      wr_data,
    output logic                busy
);

    lsu_pkg::seq_state_t state;
    lsu_pkg::seq_state_t state_nxt;
    lsu_pkg::word_addr_t word_idx;
    lsu_pkg::word_addr_t st_addr_q;
    lsu_pkg::word_addr_t next_addr_q;
    lsu_pkg::byte_en_t   be1_q;
    lsu_pkg::word_t      data1_q;
    logic                first_beat_split;

    assign word_idx = addr[9:2];
    assign byte_off = addr[1:0];
    assign rd_addr  = word_idx;  // Read issued in the request cycle.

    // Split seen while still idle means beat 1 is pending.
    assign first_beat_split = (state == lsu_pkg::seq_idle) && split;
    assign busy = first_beat_split;

    assign st_go = req & we & ~busy;
    assign ld_go = req & ~we & ~busy;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::seq_idle: begin
                if (split) begin
                    state_nxt = lsu_pkg::seq_second;
                end
            end
            lsu_pkg::seq_second: begin
                state_nxt = lsu_pkg::seq_idle;
            end
            default: begin
                state_nxt = lsu_pkg::seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lsu_pkg::seq_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (st_go) begin
            st_addr_q <= word_idx;
        end
        if (first_beat_split) begin
            // Wraps at the end of the RAM.
            next_addr_q <= lsu_pkg::word_addr_t'((int'(st_addr_q) + 1) % lsu_pkg::ram_words);
            be1_q       <= be1;
            data1_q     <= data1;
        end
    end

    always_comb begin
        if (state == lsu_pkg::seq_second) begin
            wr_addr = next_addr_q;
            wr_be   = be1_q;
            wr_data = data1_q;
        end else begin
            wr_addr = st_addr_q;
            wr_be   = be0;  // Zero unless a store was aligned last cycle.
            wr_data = data0;
        end
    end

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic                clk,
    input  lsu_pkg::word_addr_t rd_addr,
    input  lsu_pkg::word_addr_t wr_addr,
    input  lsu_pkg::byte_en_t   wr_be,
    input  lsu_pkg::word_t      wr_data,
    output lsu_pkg::word_t      rd_word
);

    lsu_pkg::word_t mem [lsu_pkg::ram_words];

    initial begin
        for (int i = 0; i < lsu_pkg::ram_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr_be[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
        rd_word <= mem[rd_addr];  // Old data on collision.
    end

endmodule

// ==== rtl/load_extract.sv ====
`timescale 1ns/100ps

module load_extract (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ld_go,
    input  lsu_pkg::funct3_t funct3,
    input  logic [1:0]       byte_off,
    input  lsu_pkg::word_t   rd_word,
    output logic             rd_valid,
    output lsu_pkg::word_t   rd_data
);

    lsu_pkg::funct3_t funct3_q;
    logic [1:0]       off_q;
    logic             valid_q;
    lsu_pkg::word_t   raw;
    lsu_pkg::word_t   result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            valid_q  <= ld_go;
            rd_valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_go) begin
            funct3_q <= funct3;
            off_q    <= byte_off;
        end
    end

    assign raw = rd_word >> {off_q, 3'b000};  // Addressed byte to lane 0.

    always_comb begin
        case (funct3_q)
            lsu_pkg::funct_lb:  result = {{24{raw[7]}}, raw[7:0]};
            lsu_pkg::funct_lbu: result = {24'd0, raw[7:0]};
            lsu_pkg::funct_lh:  result = (off_q == 2'd3) ? '0 : {{16{raw[15]}}, raw[15:0]};
            lsu_pkg::funct_lhu: result = (off_q == 2'd3) ? '0 : {16'd0, raw[15:0]};
            lsu_pkg::funct_lw:  result = (off_q == 2'd0) ? raw : '0;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            rd_data <= result;
        end
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    // Data and address widths.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  word_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  funct3_t;

    // Load codes.
    localparam funct3_t funct_lb  = 3'd0;
    localparam funct3_t funct_lh  = 3'd1;
    localparam funct3_t funct_lw  = 3'd2;
    localparam funct3_t funct_lbu = 3'd4;
    localparam funct3_t funct_lhu = 3'd5;

    // Store codes.
    localparam funct3_t funct_sb = 3'd0;
    localparam funct3_t funct_sh = 3'd1;
    localparam funct3_t funct_sw = 3'd2;

    localparam int ram_words = 256;  // Must match word_addr_t.

    // Write sequencer, second state only for a split halfword.
    typedef enum logic {
        seq_idle,
        seq_second
    } seq_state_t;

endpackage

// ==== rtl/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic             we,
    input  lsu_pkg::funct3_t funct3,
    input  lsu_pkg::addr_t   addr,
    input  lsu_pkg::word_t   wdata,
    output logic             busy,
    output logic             rd_valid,
    output lsu_pkg::word_t   rd_data
);

    logic                st_go;
    logic                ld_go;
    logic [1:0]          byte_off;
    logic                split;
    lsu_pkg::byte_en_t   be0;
    lsu_pkg::byte_en_t   be1;
    lsu_pkg::word_t      data0;
    lsu_pkg::word_t      data1;
    lsu_pkg::word_addr_t rd_addr;
    lsu_pkg::word_addr_t wr_addr;
    lsu_pkg::byte_en_t   wr_be;
    lsu_pkg::word_t      wr_data;
    lsu_pkg::word_t      rd_word;

    access_seq u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .addr     (addr),
        .st_go    (st_go),
        .ld_go    (ld_go),
        .byte_off (byte_off),
        .split    (split),
        .be0      (be0),
        .be1      (be1),
        .data0    (data0),
        .data1    (data1),
        .rd_addr  (rd_addr),
        .wr_addr  (wr_addr),
        .wr_be    (wr_be),
        .wr_data  (wr_data),
        .busy     (busy)
    );

    store_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_go    (st_go),
        .funct3   (funct3),
        .byte_off (byte_off),
        .wdata    (wdata),
        .data0    (data0),
        .data1    (data1),
        .be0      (be0),
        .be1      (be1),
        .split    (split)
    );

    data_ram u_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .wr_addr (wr_addr),
        .wr_be   (wr_be),
        .wr_data (wr_data),
        .rd_word (rd_word)
    );

    load_extract u_extract (
        .clk      (clk),
        .rst_n    (rst_n),
        .ld_go    (ld_go),
        .funct3   (funct3),
        .byte_off (byte_off),
        .rd_word  (rd_word),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

// ==== rtl/store_align.sv ====
`timescale 1ns/100ps

module store_align (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              st_go,
    input  lsu_pkg::funct3_t  funct3,
    input  logic [1:0]        byte_off,
    input  lsu_pkg::word_t    wdata,
    output lsu_pkg::word_t    data0,
    output lsu_pkg::word_t    data1,
    output lsu_pkg::byte_en_t be0,
    output lsu_pkg::byte_en_t be1,
    output logic              split
);

    lsu_pkg::word_t    data0_d;
    lsu_pkg::word_t    data1_d;
    lsu_pkg::byte_en_t be0_d;
    lsu_pkg::byte_en_t be1_d;
    logic              split_d;

    always_comb begin
        data0_d = {4{wdata[7:0]}};   // Byte in every lane.
        data1_d = {4{wdata[15:8]}};  // High byte for a second beat.
        be0_d   = '0;
        be1_d   = '0;
        split_d = 1'b0;
        case (funct3)
            lsu_pkg::funct_sb: begin
                be0_d = 4'b0001 << byte_off;
            end
            lsu_pkg::funct_sh: begin
                if (byte_off == 2'd3) begin
                    // Low byte ends this word, high byte starts the next.
                    be0_d   = 4'b1000;
                    be1_d   = 4'b0001;
                    split_d = 1'b1;
                end else begin
                    data0_d = {2{wdata[15:0]}} << {byte_off, 3'b000};
                    be0_d   = 4'b0011 << byte_off;
                end
            end
            lsu_pkg::funct_sw: begin
                if (byte_off == 2'd0) begin
                    data0_d = wdata;
                    be0_d   = 4'b1111;
                end
            end
            default: begin
                be0_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            be0   <= '0;
            be1   <= '0;
            split <= 1'b0;
        end else begin
            be0   <= st_go ? be0_d : '0;
            be1   <= st_go ? be1_d : '0;
            split <= st_go & split_d;
        end
    end

    always_ff @(posedge clk) begin
        if (st_go) begin
            data0 <= data0_d;
            data1 <= data1_d;
        end
    end

endmodule

// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/access_seq.sv
rtl/data_ram.sv
rtl/mem_stage.sv
bench/mem_stage_tb.sv
